//--- src/dma_txq_pkg.sv
// DMA transmit queue package
// Datapath widths, buffer depths, header marker and FSM state types
`default_nettype none

package dma_txq_pkg;

   //////////////////////////////
   // Datapath
   //////////////////////////////
   localparam int DATA_WIDTH = 64;
   // One ctrl bit per data byte
   localparam int CTRL_WIDTH = DATA_WIDTH / 8;

   // Ctrl value of the module header word
   localparam logic [CTRL_WIDTH-1:0] STAGE_NUMBER = 8'hff;

   // Length fields
   localparam int PKT_BYTE_CNT_WIDTH = 12;
   localparam int PKT_WORD_CNT_WIDTH = 9;

   //////////////////////////////
   // Buffering
   //////////////////////////////
   // 256 body words
   localparam int DATA_FIFO_DEPTH_BITS = 8;
   // 8 queued packet lengths
   localparam int LEN_FIFO_DEPTH_BITS = 3;
   // Free slots left when almost_full rises
   localparam int ALMOST_FULL_MARGIN = 4;

   localparam int PKT_CNT_WIDTH = 6;

   //////////////////////////////
   // FSM states
   //////////////////////////////
   typedef enum logic {
      IN_HDR,
      IN_BODY
   } in_state_e;

   typedef enum logic {
      OUT_HDR,
      OUT_BODY
   } out_state_e;

endpackage

`default_nettype wire

//--- src/dma_txq_if.sv
// Write side of the transmit queue
// Carries body words and packet lengths from ingress into the two FIFOs
`timescale 1ns/1ps
`default_nettype none

interface txq_wr_if;

   // Body word path, already little endian
   logic                                      data_wr;
   logic [dma_txq_pkg::DATA_WIDTH-1:0]         data_word;
   logic [dma_txq_pkg::CTRL_WIDTH-1:0]         data_ctrl;

   // Packet length path
   logic                                      len_wr;
   logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] len_bytes;

   // Fill levels back to the writer
   logic                                      data_almost_full;
   logic                                      data_full;
   logic                                      len_full;

   modport src (
      output data_wr,
      output data_word,
      output data_ctrl,
      output len_wr,
      output len_bytes,
      input  data_almost_full,
      input  data_full,
      input  len_full
   );

   modport dst (
      input  data_wr,
      input  data_word,
      input  data_ctrl,
      input  len_wr,
      input  len_bytes,
      output data_almost_full,
      output data_full,
      output len_full
   );

endinterface

`default_nettype wire

//--- src/sync_fwft_fifo.sv
// Single clock first-word-fall-through FIFO
// Head word sits on dout whenever the FIFO is not empty
`timescale 1ns/1ps
`default_nettype none

module sync_fwft_fifo #(
   parameter int WIDTH      = 72,
   parameter int DEPTH_BITS = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             almost_full,
   output logic             empty
);

   localparam int DEPTH = 1 << DEPTH_BITS;
   localparam logic [DEPTH_BITS:0] FULL_LEVEL = (DEPTH_BITS+1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] AF_LEVEL =
      (DEPTH_BITS+1)'(DEPTH - dma_txq_pkg::ALMOST_FULL_MARGIN);

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;

   // Storage array
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Fall-through head
   assign dout        = mem[rd_ptr];
   assign full        = (count == FULL_LEVEL);
   assign almost_full = (count >= AF_LEVEL);
   assign empty       = (count == '0);

   //////////////////////////////
   // Checks
   //////////////////////////////
   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
      !(wr_en && full));

   a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
      !(rd_en && empty));

endmodule

`default_nettype wire

//--- src/txq_ingress.sv
// Transmit queue ingress
// Parses the module header, byte-swaps body words and writes both FIFOs
`timescale 1ns/1ps
`default_nettype none

module txq_ingress (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic [dma_txq_pkg::DATA_WIDTH-1:0]         in_data,
   input  logic [dma_txq_pkg::CTRL_WIDTH-1:0]         in_ctrl,
   input  logic                                      in_wr,
   txq_wr_if.src                                     wr,
   output logic                                      in_rdy,
   output logic                                      tx_pkt_stored,
   output logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] tx_pkt_byte_cnt,
   output logic [dma_txq_pkg::PKT_WORD_CNT_WIDTH-1:0] tx_pkt_word_cnt
);

   dma_txq_pkg::in_state_e state;
   dma_txq_pkg::in_state_e state_nxt;

   logic                                      hdr_seen;
   logic                                      eop_seen;
   logic                                      len_wr_q;
   logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] hdr_bytes;
   logic [dma_txq_pkg::PKT_WORD_CNT_WIDTH-1:0] hdr_words;

   //////////////////////////////
   // Length from the header
   //////////////////////////////
   assign hdr_bytes = in_data[dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0];

   // Round up to whole 8-byte words
   assign hdr_words =
      hdr_bytes[dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1 -: dma_txq_pkg::PKT_WORD_CNT_WIDTH]
      + dma_txq_pkg::PKT_WORD_CNT_WIDTH'(
         |hdr_bytes[dma_txq_pkg::PKT_BYTE_CNT_WIDTH-dma_txq_pkg::PKT_WORD_CNT_WIDTH-1:0]);

   // Big endian user datapath to little endian host order
   always_comb begin
      for (int k = 0; k < dma_txq_pkg::CTRL_WIDTH; k++) begin
         wr.data_ctrl[k]       = in_ctrl[dma_txq_pkg::CTRL_WIDTH-1-k];
         wr.data_word[8*k +: 8] = in_data[dma_txq_pkg::DATA_WIDTH-8-8*k +: 8];
      end
   end

   assign in_rdy = !wr.data_almost_full && !wr.len_full;

   //////////////////////////////
   // Write-side FSM
   //////////////////////////////
   always_comb begin
      state_nxt  = state;
      hdr_seen   = 1'b0;
      eop_seen   = 1'b0;
      wr.data_wr = 1'b0;
      case (state)
         dma_txq_pkg::IN_HDR: begin
            if (in_wr) begin
               if (in_ctrl == dma_txq_pkg::STAGE_NUMBER) begin
                  hdr_seen = 1'b1;
               end else if (in_ctrl == '0) begin
                  // First body word
                  wr.data_wr = 1'b1;
                  state_nxt  = dma_txq_pkg::IN_BODY;
               end
            end
         end
         dma_txq_pkg::IN_BODY: begin
            if (in_wr) begin
               wr.data_wr = 1'b1;
               if (in_ctrl != '0) begin
                  eop_seen  = 1'b1;
                  state_nxt = dma_txq_pkg::IN_HDR;
               end
            end
         end
         default: state_nxt = dma_txq_pkg::IN_HDR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state           <= dma_txq_pkg::IN_HDR;
         len_wr_q        <= 1'b0;
         tx_pkt_stored   <= 1'b0;
         tx_pkt_byte_cnt <= '0;
         tx_pkt_word_cnt <= '0;
      end else begin
         state         <= state_nxt;
         len_wr_q      <= hdr_seen;
         tx_pkt_stored <= eop_seen;
         if (hdr_seen) begin
            tx_pkt_byte_cnt <= hdr_bytes;
            tx_pkt_word_cnt <= hdr_words;
         end
      end
   end

   // Length goes in one cycle after the header
   assign wr.len_wr    = len_wr_q;
   assign wr.len_bytes = tx_pkt_byte_cnt;

   a_wr_when_rdy: assert property (@(posedge clk) disable iff (reset)
      in_wr |-> in_rdy);

endmodule

`default_nettype wire

//--- src/txq_egress.sv
// Transmit queue egress
// Presents the length word, then the body words, one per DMA read
`timescale 1ns/1ps
`default_nettype none

module txq_egress (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      dma_rd,
   input  logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] len_out,
   input  logic [dma_txq_pkg::DATA_WIDTH-1:0]         data_out,
   input  logic [dma_txq_pkg::CTRL_WIDTH-1:0]         ctrl_out,
   input  logic                                      data_empty,
   output logic                                      len_rd,
   output logic                                      data_rd,
   output logic [dma_txq_pkg::DATA_WIDTH-1:0]         dma_rd_data,
   output logic [dma_txq_pkg::CTRL_WIDTH-1:0]         dma_rd_ctrl,
   output logic                                      tx_pkt_removed,
   output logic                                      in_hdr
);

   dma_txq_pkg::out_state_e state;
   dma_txq_pkg::out_state_e state_nxt;

   //////////////////////////////
   // DMA read FSM
   //////////////////////////////
   always_comb begin
      state_nxt      = state;
      len_rd         = 1'b0;
      data_rd        = 1'b0;
      tx_pkt_removed = 1'b0;
      dma_rd_data    = '0;
      dma_rd_ctrl    = '0;
      case (state)
         dma_txq_pkg::OUT_HDR: begin
            // Length word, zero extended with ctrl 0
            dma_rd_data = {{(dma_txq_pkg::DATA_WIDTH-dma_txq_pkg::PKT_BYTE_CNT_WIDTH){1'b0}},
                           len_out};
            if (dma_rd) begin
               len_rd    = 1'b1;
               state_nxt = dma_txq_pkg::OUT_BODY;
            end
         end
         dma_txq_pkg::OUT_BODY: begin
            dma_rd_data = data_out;
            dma_rd_ctrl = ctrl_out;
            // Reads on an empty buffer are dropped here
            data_rd = dma_rd && !data_empty;
            if (data_rd && ctrl_out != '0) begin
               tx_pkt_removed = 1'b1;
               state_nxt      = dma_txq_pkg::OUT_HDR;
            end
         end
         default: state_nxt = dma_txq_pkg::OUT_HDR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dma_txq_pkg::OUT_HDR;
      end else begin
         state <= state_nxt;
      end
   end

   assign in_hdr = (state == dma_txq_pkg::OUT_HDR);

endmodule

`default_nettype wire

//--- src/txq_occupancy.sv
// Queue occupancy tracker
// Counts stored packets, drives packet-available and the error flags
`timescale 1ns/1ps
`default_nettype none

module txq_occupancy (
   input  logic clk,
   input  logic reset,
   input  logic tx_pkt_stored,
   input  logic tx_pkt_removed,
   input  logic in_hdr,
   input  logic dma_rd,
   input  logic data_empty,
   input  logic data_full,
   input  logic in_wr,
   input  logic tx_queue_en,
   output logic dma_pkt_avail,
   output logic tx_q_underrun,
   output logic tx_q_overrun
);

   logic [dma_txq_pkg::PKT_CNT_WIDTH-1:0] pkt_cnt;
   logic                                  avail_q;
   logic                                  last_len_rd;

   // Length word of the only queued packet is being taken
   assign last_len_rd = (pkt_cnt == dma_txq_pkg::PKT_CNT_WIDTH'(1)) && in_hdr && dma_rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_cnt       <= '0;
         avail_q       <= 1'b0;
         tx_q_underrun <= 1'b0;
         tx_q_overrun  <= 1'b0;
      end else begin
         case ({tx_pkt_removed, tx_pkt_stored})
            2'b01:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b10:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase

         // A new packet wins over the clear
         if (tx_pkt_stored) begin
            avail_q <= 1'b1;
         end else if (last_len_rd) begin
            avail_q <= 1'b0;
         end

         tx_q_underrun <= dma_rd && data_empty && !in_hdr;
         tx_q_overrun  <= in_wr && data_full;
      end
   end

   assign dma_pkt_avail = avail_q && tx_queue_en;

   //////////////////////////////
   // Checks
   //////////////////////////////
   a_cnt_no_wrap: assert property (@(posedge clk) disable iff (reset)
      !(tx_pkt_stored && !tx_pkt_removed && pkt_cnt == '1) &&
      !(tx_pkt_removed && !tx_pkt_stored && pkt_cnt == '0));

endmodule

`default_nettype wire

//--- src/cpu_dma_tx_queue.sv
// CPU DMA transmit queue
// Buffers packets from the user datapath for reading by the host DMA engine
`timescale 1ns/1ps
`default_nettype none

module cpu_dma_tx_queue (
   input  logic                                      clk,
   input  logic                                      reset,

   // User datapath
   input  logic [dma_txq_pkg::DATA_WIDTH-1:0]         in_data,
   input  logic [dma_txq_pkg::CTRL_WIDTH-1:0]         in_ctrl,
   input  logic                                      in_wr,
   output logic                                      in_rdy,

   // DMA reader
   output logic                                      dma_pkt_avail,
   input  logic                                      dma_rd,
   output logic [dma_txq_pkg::DATA_WIDTH-1:0]         dma_rd_data,
   output logic [dma_txq_pkg::CTRL_WIDTH-1:0]         dma_rd_ctrl,

   // Control and status
   input  logic                                      tx_queue_en,
   output logic                                      tx_pkt_stored,
   output logic                                      tx_pkt_removed,
   output logic                                      tx_q_underrun,
   output logic                                      tx_q_overrun,
   output logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] tx_pkt_byte_cnt,
   output logic [dma_txq_pkg::PKT_WORD_CNT_WIDTH-1:0] tx_pkt_word_cnt
);

   txq_wr_if wr_if ();

   logic [dma_txq_pkg::DATA_WIDTH-1:0]         data_out;
   logic [dma_txq_pkg::CTRL_WIDTH-1:0]         ctrl_out;
   logic [dma_txq_pkg::PKT_BYTE_CNT_WIDTH-1:0] len_out;
   logic                                      data_empty;
   logic                                      len_empty;
   logic                                      data_rd;
   logic                                      len_rd;
   logic                                      in_hdr;

   txq_ingress u_ingress (
      .clk             (clk),
      .reset           (reset),
      .in_data         (in_data),
      .in_ctrl         (in_ctrl),
      .in_wr           (in_wr),
      .wr              (wr_if.src),
      .in_rdy          (in_rdy),
      .tx_pkt_stored   (tx_pkt_stored),
      .tx_pkt_byte_cnt (tx_pkt_byte_cnt),
      .tx_pkt_word_cnt (tx_pkt_word_cnt)
   );

   //////////////////////////////
   // Buffers
   //////////////////////////////
   // Ctrl travels beside its data word
   sync_fwft_fifo #(
      .WIDTH      (dma_txq_pkg::CTRL_WIDTH + dma_txq_pkg::DATA_WIDTH),
      .DEPTH_BITS (dma_txq_pkg::DATA_FIFO_DEPTH_BITS)
   ) data_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (wr_if.data_wr),
      .din         ({wr_if.data_ctrl, wr_if.data_word}),
      .rd_en       (data_rd),
      .dout        ({ctrl_out, data_out}),
      .full        (wr_if.data_full),
      .almost_full (wr_if.data_almost_full),
      .empty       (data_empty)
   );

   sync_fwft_fifo #(
      .WIDTH      (dma_txq_pkg::PKT_BYTE_CNT_WIDTH),
      .DEPTH_BITS (dma_txq_pkg::LEN_FIFO_DEPTH_BITS)
   ) len_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (wr_if.len_wr),
      .din         (wr_if.len_bytes),
      .rd_en       (len_rd),
      .dout        (len_out),
      .full        (wr_if.len_full),
      .almost_full (),
      .empty       (len_empty)
   );

   txq_egress u_egress (
      .clk            (clk),
      .reset          (reset),
      .dma_rd         (dma_rd),
      .len_out        (len_out),
      .data_out       (data_out),
      .ctrl_out       (ctrl_out),
      .data_empty     (data_empty),
      .len_rd         (len_rd),
      .data_rd        (data_rd),
      .dma_rd_data    (dma_rd_data),
      .dma_rd_ctrl    (dma_rd_ctrl),
      .tx_pkt_removed (tx_pkt_removed),
      .in_hdr         (in_hdr)
   );

   txq_occupancy u_occupancy (
      .clk            (clk),
      .reset          (reset),
      .tx_pkt_stored  (tx_pkt_stored),
      .tx_pkt_removed (tx_pkt_removed),
      .in_hdr         (in_hdr),
      .dma_rd         (dma_rd),
      .data_empty     (data_empty),
      .data_full      (wr_if.data_full),
      .in_wr          (in_wr),
      .tx_queue_en    (tx_queue_en),
      .dma_pkt_avail  (dma_pkt_avail),
      .tx_q_underrun  (tx_q_underrun),
      .tx_q_overrun   (tx_q_overrun)
   );

   // A packet flagged as available always has its length queued
   a_avail_has_len: assert property (@(posedge clk) disable iff (reset)
      dma_pkt_avail |-> !len_empty);

endmodule

`default_nettype wire

//--- tests/tb_txq_model.svh
// Transmit queue testbench model
// Packet generator and the expected DMA word sequence of each packet
`ifndef TB_TXQ_MODEL_SVH
`define TB_TXQ_MODEL_SVH

logic [31:0] lcg_state = 32'd88530;

// Packet being generated, {ctrl, data} in user datapath order
logic [71:0] pkt_words[$];
int          pkt_len;

// Expected DMA words, {ctrl, data}, oldest first
logic [71:0] exp_q[$];

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic int words_for_bytes(input int len);
   return (len + 7) / 8;
endfunction

// Header word, then body words with a one-hot end-of-packet ctrl
function automatic void make_packet(input int len);
   int          nwords;
   int          tail;
   logic [31:0] hi;
   logic [31:0] lo;
   logic [7:0]  ctrl;
   nwords  = words_for_bytes(len);
   tail    = len - 8 * (nwords - 1);
   pkt_len = len;
   pkt_words.delete();
   hi = lcg_next();
   lo = lcg_next();
   pkt_words.push_back({8'hff, hi, lo[31:12], len[11:0]});
   for (int i = 0; i < nwords; i++) begin
      hi   = lcg_next();
      lo   = lcg_next();
      ctrl = (i == nwords - 1) ? (8'h80 >> (tail - 1)) : 8'h00;
      pkt_words.push_back({ctrl, hi, lo});
   end
endfunction

// Host order: length word first, then every body word byte reversed
function automatic void add_expected(input int len);
   logic [63:0] swapped;
   logic [7:0]  flipped;
   exp_q.push_back({8'h00, 52'd0, len[11:0]});
   for (int i = 1; i < pkt_words.size(); i++) begin
      swapped = {<<8{pkt_words[i][63:0]}};
      flipped = {<<{pkt_words[i][71:64]}};
      exp_q.push_back({flipped, swapped});
   end
endfunction

`endif

//--- tests/tb_cpu_dma_tx_queue.sv
// Transmit queue testbench
// Drives packets in, reads them back over the DMA side and checks the status
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dma_tx_queue;

   localparam int TIMEOUT_CYCLES = 2000;

   logic        clk;
   logic        reset;
   logic [63:0] in_data;
   logic [7:0]  in_ctrl;
   logic        in_wr;
   logic        in_rdy;
   logic        dma_pkt_avail;
   logic        dma_rd;
   logic [63:0] dma_rd_data;
   logic [7:0]  dma_rd_ctrl;
   logic        tx_queue_en;
   logic        tx_pkt_stored;
   logic        tx_pkt_removed;
   logic        tx_q_underrun;
   logic        tx_q_overrun;
   logic [11:0] tx_pkt_byte_cnt;
   logic [8:0]  tx_pkt_word_cnt;

   int stored_cnt = 0;
   int removed_cnt = 0;
   int underrun_cnt = 0;
   int overrun_cnt = 0;

   `include "tb_txq_model.svh"

   cpu_dma_tx_queue dut_i (
      .clk             (clk),
      .reset           (reset),
      .in_data         (in_data),
      .in_ctrl         (in_ctrl),
      .in_wr           (in_wr),
      .in_rdy          (in_rdy),
      .dma_pkt_avail   (dma_pkt_avail),
      .dma_rd          (dma_rd),
      .dma_rd_data     (dma_rd_data),
      .dma_rd_ctrl     (dma_rd_ctrl),
      .tx_queue_en     (tx_queue_en),
      .tx_pkt_stored   (tx_pkt_stored),
      .tx_pkt_removed  (tx_pkt_removed),
      .tx_q_underrun   (tx_q_underrun),
      .tx_q_overrun    (tx_q_overrun),
      .tx_pkt_byte_cnt (tx_pkt_byte_cnt),
      .tx_pkt_word_cnt (tx_pkt_word_cnt)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Status pulses, counted away from the active edge
   always @(negedge clk) begin
      if (!reset) begin
         if (tx_pkt_stored) stored_cnt++;
         if (tx_pkt_removed) removed_cnt++;
         if (tx_q_underrun) underrun_cnt++;
         if (tx_q_overrun) overrun_cnt++;
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////
   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         stop_with_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                   name, got, exp));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #0.5;
   endtask

   task automatic wait_avail();
      int guard;
      guard = 0;
      while (!dma_pkt_avail) begin
         next_cycle();
         guard++;
         if (guard > TIMEOUT_CYCLES) stop_with_error("timeout waiting for dma_pkt_avail");
      end
   endtask

   task automatic wait_stored(input int target);
      int guard;
      guard = 0;
      while (stored_cnt < target) begin
         next_cycle();
         guard++;
         if (guard > TIMEOUT_CYCLES) stop_with_error("timeout waiting for tx_pkt_stored");
      end
   endtask

   task automatic wait_underrun(input int target);
      int guard;
      guard = 0;
      while (underrun_cnt < target) begin
         next_cycle();
         guard++;
         if (guard > TIMEOUT_CYCLES) stop_with_error("timeout waiting for tx_q_underrun");
      end
   endtask

   task automatic wait_rdy_low();
      int guard;
      guard = 0;
      while (in_rdy) begin
         next_cycle();
         guard++;
         if (guard > TIMEOUT_CYCLES) stop_with_error("in_rdy never dropped while filling");
      end
   endtask

   // Words first..last of the current packet, held back while in_rdy is low
   task automatic send_words(input int first, input int last);
      int guard;
      for (int i = first; i <= last; i++) begin
         guard = 0;
         while (!in_rdy) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT_CYCLES) stop_with_error("timeout waiting for in_rdy");
         end
         {in_ctrl, in_data} = pkt_words[i];
         in_wr = 1'b1;
         next_cycle();
         in_wr = 1'b0;
         if (i == 0) begin
            check_value("tx_pkt_byte_cnt", 64'(tx_pkt_byte_cnt), 64'(pkt_len));
            check_value("tx_pkt_word_cnt", 64'(tx_pkt_word_cnt),
                        64'(words_for_bytes(pkt_len)));
         end
      end
   endtask

   task automatic send_packet(input int len);
      make_packet(len);
      add_expected(len);
      send_words(0, pkt_words.size() - 1);
   endtask

   // Compare the word on the DMA side, then take it with one strobe
   task automatic read_one(output logic [7:0] ctrl);
      logic [71:0] exp;
      if (exp_q.size() == 0) stop_with_error("DMA word read with nothing expected");
      exp = exp_q.pop_front();
      check_value("dma_rd_data", dma_rd_data, exp[63:0]);
      check_value("dma_rd_ctrl", 64'(dma_rd_ctrl), 64'(exp[71:64]));
      ctrl = exp[71:64];
      dma_rd = 1'b1;
      next_cycle();
      dma_rd = 1'b0;
   endtask

   task automatic read_body();
      logic [7:0] ctrl;
      do begin
         read_one(ctrl);
      end while (ctrl == 8'h00);
   endtask

   task automatic read_packet();
      logic [7:0] ctrl;
      wait_avail();
      read_one(ctrl);
      read_body();
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin
      int         base_stored;
      int         base_removed;
      logic [7:0] ctrl;
      reset       = 1'b1;
      in_data     = '0;
      in_ctrl     = '0;
      in_wr       = 1'b0;
      dma_rd      = 1'b0;
      tx_queue_en = 1'b1;
      repeat (16) @(posedge clk);
      #0.5;
      reset = 1'b0;
      next_cycle();
      check_value("in_rdy", 64'(in_rdy), 64'd1);
      check_value("dma_pkt_avail", 64'(dma_pkt_avail), 64'd0);

      // One packet through the queue
      send_packet(100);
      read_packet();
      check_value("stored pulses", 64'(stored_cnt), 64'd1);
      check_value("removed pulses", 64'(removed_cnt), 64'd1);

      // Five queued packets, avail held until the last length word
      base_stored  = stored_cnt;
      base_removed = removed_cnt;
      for (int p = 0; p < 5; p++) begin
         send_packet(16 + int'(lcg_next() % 241));
      end
      wait_stored(base_stored + 5);
      wait_avail();
      for (int p = 0; p < 5; p++) begin
         check_value("dma_pkt_avail", 64'(dma_pkt_avail), 64'd1);
         read_one(ctrl);
         read_body();
      end
      check_value("dma_pkt_avail", 64'(dma_pkt_avail), 64'd0);
      check_value("stored pulses", 64'(stored_cnt - base_stored), 64'd5);
      check_value("removed pulses", 64'(removed_cnt - base_removed), 64'd5);

      // Queue disabled, then enabled
      tx_queue_en = 1'b0;
      base_stored = stored_cnt;
      send_packet(64);
      send_packet(16 + int'(lcg_next() % 241));
      wait_stored(base_stored + 2);
      next_cycle();
      next_cycle();
      check_value("dma_pkt_avail", 64'(dma_pkt_avail), 64'd0);
      tx_queue_en = 1'b1;
      next_cycle();
      check_value("dma_pkt_avail", 64'(dma_pkt_avail), 64'd1);
      read_packet();
      read_packet();

      // Fill until in_rdy drops, then drain while the sender resumes
      // Long packets fill the data FIFO well before the length FIFO
      base_stored  = stored_cnt;
      base_removed = removed_cnt;
      fork
         begin
            for (int p = 0; p < 6; p++) begin
               send_packet(512);
            end
         end
         begin
            wait_rdy_low();
            for (int p = 0; p < 6; p++) begin
               read_packet();
            end
         end
      join
      check_value("in_rdy", 64'(in_rdy), 64'd1);
      check_value("stored pulses", 64'(stored_cnt - base_stored), 64'd6);
      check_value("removed pulses", 64'(removed_cnt - base_removed), 64'd6);
      check_value("tx_q_underrun pulses", 64'(underrun_cnt), 64'd0);
      check_value("tx_q_overrun pulses", 64'(overrun_cnt), 64'd0);

      // Strobe on an empty buffer in OUT_BODY
      tx_queue_en = 1'b0;
      make_packet(40);
      add_expected(40);
      send_words(0, 0);
      // Length write trails the header by one cycle
      next_cycle();
      read_one(ctrl);
      dma_rd = 1'b1;
      next_cycle();
      dma_rd = 1'b0;
      wait_underrun(1);
      send_words(1, pkt_words.size() - 1);
      read_body();
      check_value("tx_q_underrun pulses", 64'(underrun_cnt), 64'd1);
      check_value("tx_q_overrun pulses", 64'(overrun_cnt), 64'd0);
      check_value("words left", 64'(exp_q.size()), 64'd0);

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- cpu_dma_tx_queue.f
+incdir+tests
src/dma_txq_pkg.sv
src/dma_txq_if.sv
src/sync_fwft_fifo.sv
src/txq_ingress.sv
src/txq_egress.sv
src/txq_occupancy.sv
src/cpu_dma_tx_queue.sv
tests/tb_cpu_dma_tx_queue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the transmit queue testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   -f cpu_dma_tx_queue.f \
   --top-module tb_cpu_dma_tx_queue \
   -o tb_cpu_dma_tx_queue
./obj_dir/tb_cpu_dma_tx_queue
